// File: hdl/dcache_consts.svh
// Geometry and address widths of the two-way data cache.
// Included by the package and by every module that sizes a port or a memory.
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ---------------------------------------------------------------------------
// Cache geometry
// ---------------------------------------------------------------------------

// Sets and ways per set.
`define DC_SETS 2
`define DC_WAYS 2

// Block and cache word widths in bits.
`define DC_BLOCK_W 512
`define DC_WORD_W 32

// ---------------------------------------------------------------------------
// Address and data widths
// ---------------------------------------------------------------------------

// CPU side.
`define DC_ADDR_W 64
`define DC_REG_W 64

// Memory side, block aligned.
`define DC_MEM_ADDR_W 32
`define DC_BLOCK_OFF_W 6

`endif

// File: hdl/dcache_pkg.sv
// Types shared by the data cache modules.
// Derived widths are computed here from the geometry macros.
`include "dcache_consts.svh"

package dcache_pkg;

    // -----------------------------------------------------------------------
    // Derived widths
    // -----------------------------------------------------------------------
    localparam int DC_WORDS      = `DC_BLOCK_W / `DC_WORD_W;
    localparam int DC_BYTES      = `DC_BLOCK_W / 8;
    localparam int DC_WORD_OFF_W = $clog2(DC_WORDS);
    localparam int DC_BYTE_OFF_W = $clog2(`DC_WORD_W / 8);
    localparam int DC_INDEX_W    = $clog2(`DC_SETS);
    localparam int DC_WAY_W      = $clog2(`DC_WAYS);
    localparam int DC_LRU_W      = $clog2(`DC_WAYS);
    localparam int DC_TAG_W      = `DC_ADDR_W - DC_INDEX_W - DC_WORD_OFF_W - DC_BYTE_OFF_W;

    // -----------------------------------------------------------------------
    // Types
    // -----------------------------------------------------------------------
    typedef logic [DC_TAG_W-1:0]   dc_tag_t;
    typedef logic [DC_INDEX_W-1:0] dc_index_t;
    typedef logic [DC_WAY_W-1:0]   dc_way_t;

    // CPU address split, top bits first.
    typedef struct packed {
        dc_tag_t                  tag;
        dc_index_t                index;
        logic [DC_WORD_OFF_W-1:0] word_off;
        logic [DC_BYTE_OFF_W-1:0] byte_off;
    } dc_addr_t;

    // Store size, as in funct3 of SB/SH/SW/SD.
    typedef enum logic [1:0] {
        st_byte  = 2'd0,
        st_half  = 2'd1,
        st_word  = 2'd2,
        st_dword = 2'd3
    } dc_store_e;

    // Strobes from the cache controller.
    typedef struct packed {
        logic write_en;
        logic valid_update;
        logic lru_update;
        logic block_write_en;
    } dc_ctrl_t;

    // One block, addressed by byte for stores and by word for loads.
    typedef union packed {
        logic [DC_BYTES-1:0][7:0]            bytes;
        logic [DC_WORDS-1:0][`DC_WORD_W-1:0] words;
    } dc_block_u;

endpackage

// File: hdl/store_align_check.sv
// RISC-V store alignment rule for the data cache.
// Flags a store whose address is not a multiple of its size.
`include "dcache_consts.svh"

module store_align_check (
    input  dcache_pkg::dc_store_e      i_store_type,
    input  logic [`DC_BLOCK_OFF_W-1:0] i_offset,
    output logic                       o_misaligned
);
    import dcache_pkg::*;

    logic s_half_ma;
    logic s_word_ma;
    logic s_dword_ma;

    // Byte offset sits in bits 1:0, word offset starts at bit 2.
    assign s_half_ma  = i_offset[0];
    assign s_word_ma  = |i_offset[DC_BYTE_OFF_W-1:0];
    assign s_dword_ma = s_word_ma | i_offset[DC_BYTE_OFF_W];

    always_comb begin
        case (i_store_type)
            st_dword: o_misaligned = s_dword_ma;
            st_word:  o_misaligned = s_word_ma;
            st_half:  o_misaligned = s_half_ma;
            default:  o_misaligned = 1'b0;
        endcase
    end

endmodule

// File: hdl/tag_array.sv
// Tag, valid and dirty state of the data cache with hit detection.
// Also selects the memory-side address for fills and write-backs.
`include "dcache_consts.svh"

module tag_array (
    input  logic                      clk,
    input  logic                      arst,
    input  dcache_pkg::dc_ctrl_t      i_ctrl,
    input  dcache_pkg::dc_tag_t       i_tag,
    input  dcache_pkg::dc_index_t     i_index,
    input  logic [`DC_MEM_ADDR_W-1:0] i_fill_addr,
    input  logic                      i_addr_control,
    input  dcache_pkg::dc_way_t       i_victim_way,
    output logic                      o_hit,
    output dcache_pkg::dc_way_t       o_match_way,
    output logic                      o_dirty,
    output logic [`DC_MEM_ADDR_W-1:0] o_mem_addr
);
    import dcache_pkg::*;

    // Tag bits that fit in the memory-side address.
    localparam int WB_TAG_W = `DC_MEM_ADDR_W - DC_INDEX_W - `DC_BLOCK_OFF_W;

    dc_tag_t                            tag_mem [`DC_SETS][`DC_WAYS];
    logic [`DC_SETS-1:0][`DC_WAYS-1:0]  valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0]  dirty_q;

    logic [`DC_WAYS-1:0]                s_hit;
    dc_tag_t                            s_victim_tag;
    logic [`DC_MEM_ADDR_W-1:0]          s_wb_addr;

    // -----------------------------------------------------------------------
    // Lookup
    // -----------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            s_hit[w] = valid_q[i_index][w] && (tag_mem[i_index][w] == i_tag);
        end
    end

    assign o_hit = |s_hit;

    // Lowest hit way wins; on a miss the victim is addressed.
    always_comb begin
        o_match_way = i_victim_way;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (s_hit[w]) begin
                o_match_way = dc_way_t'(w);
            end
        end
    end

    assign o_dirty      = dirty_q[i_index][i_victim_way];
    assign s_victim_tag = tag_mem[i_index][i_victim_way];

    // Write-back address rebuilt from the victim tag.
    assign s_wb_addr  = {s_victim_tag[WB_TAG_W-1:0], i_index, {`DC_BLOCK_OFF_W{1'b0}}};
    assign o_mem_addr = i_addr_control ? i_fill_addr : s_wb_addr;

    // -----------------------------------------------------------------------
    // State update
    // -----------------------------------------------------------------------

    // New tag only on a fill.
    always_ff @(posedge clk) begin
        if (i_ctrl.block_write_en && !i_ctrl.write_en) begin
            tag_mem[i_index][i_victim_way] <= i_tag;
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_q <= '0;
        end else if (i_ctrl.valid_update) begin
            valid_q[i_index][i_victim_way] <= 1'b1;
        end
    end

    // A store dirties the line, a fill cleans it.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            dirty_q <= '0;
        end else if (i_ctrl.write_en) begin
            dirty_q[i_index][o_match_way] <= 1'b1;
        end else if (i_ctrl.block_write_en) begin
            dirty_q[i_index][i_victim_way] <= 1'b0;
        end
    end

endmodule

// File: hdl/lru_tracker.sv
// LRU counters per set and way, and victim selection for the data cache.
`include "dcache_consts.svh"

module lru_tracker (
    input  logic                  clk,
    input  logic                  arst,
    input  dcache_pkg::dc_ctrl_t  i_ctrl,
    input  dcache_pkg::dc_index_t i_index,
    input  dcache_pkg::dc_way_t   i_match_way,
    output dcache_pkg::dc_way_t   o_victim_way
);
    import dcache_pkg::*;

    // Counter value of the most recently used way.
    localparam logic [DC_LRU_W-1:0] LRU_MRU = DC_LRU_W'(`DC_WAYS - 1);

    logic [DC_LRU_W-1:0] lru_q [`DC_SETS][`DC_WAYS];
    logic [`DC_SETS-1:0] lru_set_q;

    // Set flag stays up once the set has seen an update.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            lru_set_q <= '0;
        end else if (i_ctrl.lru_update) begin
            lru_set_q[i_index] <= 1'b1;
        end
    end

    // Untouched sets are held at counter = way number.
    always_ff @(posedge clk) begin
        for (int s = 0; s < `DC_SETS; s++) begin
            if (i_ctrl.lru_update && (dc_index_t'(s) == i_index)) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    if (lru_q[s][w] > lru_q[s][i_match_way]) begin
                        lru_q[s][w] <= lru_q[s][w] - DC_LRU_W'(1);
                    end
                end
                lru_q[s][i_match_way] <= LRU_MRU;
            end else if (!lru_set_q[s]) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    lru_q[s][w] <= DC_LRU_W'(w);
                end
            end
        end
    end

    // Victim is the lowest way with a zero counter.
    always_comb begin
        o_victim_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (lru_q[i_index][w] == '0) begin
                o_victim_way = dc_way_t'(w);
            end
        end
    end

endmodule

// File: hdl/block_store.sv
// Data block memory of the cache.
// Merges sized stores into the hit way, fills the victim and reads two words.
`include "dcache_consts.svh"

module block_store (
    input  logic                                 clk,
    input  dcache_pkg::dc_ctrl_t                 i_ctrl,
    input  dcache_pkg::dc_index_t                i_index,
    input  logic [dcache_pkg::DC_WORD_OFF_W-1:0] i_word_off,
    input  logic [dcache_pkg::DC_BYTE_OFF_W-1:0] i_byte_off,
    input  dcache_pkg::dc_store_e                i_store_type,
    input  logic [`DC_REG_W-1:0]                 i_data,
    input  dcache_pkg::dc_block_u                i_fill_block,
    input  dcache_pkg::dc_way_t                  i_match_way,
    input  dcache_pkg::dc_way_t                  i_victim_way,
    output logic [`DC_REG_W-1:0]                 o_data,
    output dcache_pkg::dc_block_u                o_victim_block
);
    import dcache_pkg::*;

    localparam int OFF_W = DC_WORD_OFF_W + DC_BYTE_OFF_W;

    dc_block_u              data_mem [`DC_SETS][`DC_WAYS];

    dc_block_u              s_rd_block;
    dc_block_u              s_merged;
    logic [OFF_W-1:0]       s_base;
    logic [3:0]             s_nbytes;
    logic [`DC_WORD_W-1:0]  s_lo_word;
    logic [`DC_WORD_W-1:0]  s_hi_word;

    assign s_rd_block     = data_mem[i_index][i_match_way];
    assign o_victim_block = data_mem[i_index][i_victim_way];

    // -----------------------------------------------------------------------
    // Store merge
    // -----------------------------------------------------------------------

    // Start byte forced to the natural alignment of the size.
    always_comb begin
        case (i_store_type)
            st_dword: begin
                s_base   = {i_word_off[DC_WORD_OFF_W-1:1], {(DC_BYTE_OFF_W + 1){1'b0}}};
                s_nbytes = 4'd8;
            end
            st_word: begin
                s_base   = {i_word_off, {DC_BYTE_OFF_W{1'b0}}};
                s_nbytes = 4'd4;
            end
            st_half: begin
                s_base   = {i_word_off, i_byte_off[1], 1'b0};
                s_nbytes = 4'd2;
            end
            default: begin
                s_base   = {i_word_off, i_byte_off};
                s_nbytes = 4'd1;
            end
        endcase
    end

    always_comb begin
        s_merged = s_rd_block;
        for (int b = 0; b < 8; b++) begin
            if (b < s_nbytes) begin
                s_merged.bytes[s_base + OFF_W'(b)] = i_data[8*b +: 8];
            end
        end
    end

    // Stores go to the hit way, fills to the victim.
    always_ff @(posedge clk) begin
        if (i_ctrl.write_en) begin
            data_mem[i_index][i_match_way] <= s_merged;
        end else if (i_ctrl.block_write_en) begin
            data_mem[i_index][i_victim_way] <= i_fill_block;
        end
    end

    // -----------------------------------------------------------------------
    // Load
    // -----------------------------------------------------------------------
    assign s_lo_word = s_rd_block.words[i_word_off];

    // Nothing above the last word of the block.
    assign s_hi_word = (&i_word_off) ? '0 : s_rd_block.words[i_word_off + 1'b1];

    assign o_data = {s_hi_word, s_lo_word};

endmodule

// File: hdl/dcache_top.sv
// Two-way set-associative data cache for the load/store unit.
// Driven by an outside controller through plain strobes; reads are combinational.
`include "dcache_consts.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      arst,
    input  logic                      i_write_en,
    input  logic                      i_valid_update,
    input  logic                      i_lru_update,
    input  logic                      i_block_write_en,
    input  logic                      i_addr_control,
    input  logic [`DC_ADDR_W-1:0]     i_data_addr,
    input  logic [`DC_REG_W-1:0]      i_data,
    input  dcache_pkg::dc_block_u     i_data_block,
    input  dcache_pkg::dc_store_e     i_store_type,
    output logic [`DC_REG_W-1:0]      o_data,
    output dcache_pkg::dc_block_u     o_data_block,
    output logic                      o_hit,
    output logic                      o_dirty,
    output logic                      o_store_addr_ma,
    output logic [`DC_MEM_ADDR_W-1:0] o_addr_axi
);
    import dcache_pkg::*;

    dc_addr_t                  s_addr;
    dc_ctrl_t                  s_ctrl;
    dc_way_t                   s_match_way;
    dc_way_t                   s_victim_way;
    logic [`DC_MEM_ADDR_W-1:0] s_fill_addr;

    // -----------------------------------------------------------------------
    // Address split and strobes
    // -----------------------------------------------------------------------
    assign s_addr = dc_addr_t'(i_data_addr);

    assign s_ctrl = '{
        write_en:       i_write_en,
        valid_update:   i_valid_update,
        lru_update:     i_lru_update,
        block_write_en: i_block_write_en
    };

    // Block-aligned fill address.
    assign s_fill_addr = {i_data_addr[`DC_MEM_ADDR_W-1:`DC_BLOCK_OFF_W],
                          {`DC_BLOCK_OFF_W{1'b0}}};

    // -----------------------------------------------------------------------
    // Submodules
    // -----------------------------------------------------------------------
    store_align_check store_align_check_inst (
        .i_store_type (i_store_type),
        .i_offset     (i_data_addr[`DC_BLOCK_OFF_W-1:0]),
        .o_misaligned (o_store_addr_ma)
    );

    tag_array tag_array_inst (
        .clk            (clk),
        .arst           (arst),
        .i_ctrl         (s_ctrl),
        .i_tag          (s_addr.tag),
        .i_index        (s_addr.index),
        .i_fill_addr    (s_fill_addr),
        .i_addr_control (i_addr_control),
        .i_victim_way   (s_victim_way),
        .o_hit          (o_hit),
        .o_match_way    (s_match_way),
        .o_dirty        (o_dirty),
        .o_mem_addr     (o_addr_axi)
    );

    lru_tracker lru_tracker_inst (
        .clk          (clk),
        .arst         (arst),
        .i_ctrl       (s_ctrl),
        .i_index      (s_addr.index),
        .i_match_way  (s_match_way),
        .o_victim_way (s_victim_way)
    );

    block_store block_store_inst (
        .clk            (clk),
        .i_ctrl         (s_ctrl),
        .i_index        (s_addr.index),
        .i_word_off     (s_addr.word_off),
        .i_byte_off     (s_addr.byte_off),
        .i_store_type   (i_store_type),
        .i_data         (i_data),
        .i_fill_block   (i_data_block),
        .i_match_way    (s_match_way),
        .i_victim_way   (s_victim_way),
        .o_data         (o_data),
        .o_victim_block (o_data_block)
    );

endmodule

// File: tb/dcache_tb.sv
// Self-checking testbench for the two-way data cache.
// Drives the strobes the way the cache controller does and checks all outputs against a model.
`include "dcache_consts.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 8;
    localparam int WB_TAG_W    = `DC_MEM_ADDR_W - DC_INDEX_W - `DC_BLOCK_OFF_W;

    // Strobe sets in the order write, valid, lru, block write.
    localparam dc_ctrl_t CTRL_STORE = dc_ctrl_t'(4'b1000);
    localparam dc_ctrl_t CTRL_VALID = dc_ctrl_t'(4'b0100);
    localparam dc_ctrl_t CTRL_LRU   = dc_ctrl_t'(4'b0010);
    localparam dc_ctrl_t CTRL_FILL  = dc_ctrl_t'(4'b0001);

    typedef struct packed {
        logic                      hit;
        logic                      dirty;
        logic                      store_ma;
        logic                      data_known;
        logic                      block_known;
        logic                      axi_known;
        logic [`DC_MEM_ADDR_W-1:0] addr_axi;
        logic [`DC_REG_W-1:0]      data;
        dc_block_u                 block;
    } expected_t;

    logic                      clk;
    logic                      arst;
    logic                      write_en;
    logic                      valid_update;
    logic                      lru_update;
    logic                      block_write_en;
    logic                      addr_control;
    logic [`DC_ADDR_W-1:0]     data_addr;
    logic [`DC_REG_W-1:0]      data;
    dc_block_u                 data_block;
    dc_store_e                 store_type;
    logic [`DC_REG_W-1:0]      rd_data;
    dc_block_u                 victim_block;
    logic                      hit;
    logic                      dirty;
    logic                      store_ma;
    logic [`DC_MEM_ADDR_W-1:0] addr_axi;

    // Reference model of the cache state.
    dc_tag_t   m_tag     [`DC_SETS][`DC_WAYS];
    dc_block_u m_block   [`DC_SETS][`DC_WAYS];
    logic      m_valid   [`DC_SETS][`DC_WAYS];
    logic      m_dirty   [`DC_SETS][`DC_WAYS];
    logic      m_known   [`DC_SETS][`DC_WAYS];
    int        m_lru     [`DC_SETS][`DC_WAYS];
    logic      m_lru_set [`DC_SETS];

    logic [31:0] seed;
    int          err_count;
    logic        check_en;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache_top dcache_top_inst (
        .clk              (clk),
        .arst             (arst),
        .i_write_en       (write_en),
        .i_valid_update   (valid_update),
        .i_lru_update     (lru_update),
        .i_block_write_en (block_write_en),
        .i_addr_control   (addr_control),
        .i_data_addr      (data_addr),
        .i_data           (data),
        .i_data_block     (data_block),
        .i_store_type     (store_type),
        .o_data           (rd_data),
        .o_data_block     (victim_block),
        .o_hit            (hit),
        .o_dirty          (dirty),
        .o_store_addr_ma  (store_ma),
        .o_addr_axi       (addr_axi)
    );

    // -----------------------------------------------------------------------
    // Stimulus helpers
    // -----------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Small ranges come from the upper bits, the low LCG bits repeat quickly.
    function automatic int random_below(int n);
        logic [31:0] r;
        r = next_random();
        return int'(r[31:16]) % n;
    endfunction

    function automatic dc_block_u random_block();
        dc_block_u blk;
        for (int i = 0; i < DC_WORDS; i++) begin
            blk.words[i] = next_random();
        end
        return blk;
    endfunction

    function automatic dc_tag_t random_tag();
        return dc_tag_t'({next_random(), next_random()});
    endfunction

    function automatic logic [`DC_ADDR_W-1:0] make_addr(dc_tag_t tag, int idx, int off);
        return {tag, dc_index_t'(idx), 6'(off)};
    endfunction

    // -----------------------------------------------------------------------
    // Reference model
    // -----------------------------------------------------------------------
    task automatic reset_model();
        for (int s = 0; s < `DC_SETS; s++) begin
            m_lru_set[s] = 1'b0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_known[s][w] = 1'b0;
                m_lru[s][w]   = w;
            end
        end
    endtask

    function automatic int victim_of(int idx);
        int v;
        v = 0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (m_lru[idx][w] == 0) begin
                v = w;
            end
        end
        return v;
    endfunction

    // Lowest hit way or the victim on a miss.
    function automatic int match_way_of(int idx, dc_tag_t tag);
        int mw;
        mw = victim_of(idx);
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                mw = w;
            end
        end
        return mw;
    endfunction

    task automatic update_model();
        dc_addr_t a;
        int       idx;
        int       vic;
        int       mw;
        int       nbytes;
        int       base;
        int       ref_cnt;
        a   = dc_addr_t'(data_addr);
        idx = int'(a.index);
        vic = victim_of(idx);
        mw  = match_way_of(idx, a.tag);
        if (write_en) begin
            nbytes = 1 << int'(store_type);
            base   = int'(data_addr[5:0]) & ~(nbytes - 1);
            for (int b = 0; b < nbytes; b++) begin
                m_block[idx][mw].bytes[base + b] = data[8*b +: 8];
            end
            m_dirty[idx][mw] = 1'b1;
        end else if (block_write_en) begin
            m_block[idx][vic] = data_block;
            m_tag[idx][vic]   = a.tag;
            m_known[idx][vic] = 1'b1;
            m_dirty[idx][vic] = 1'b0;
        end
        if (valid_update) begin
            m_valid[idx][vic] = 1'b1;
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            if (!m_lru_set[s] && !(lru_update && s == idx)) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    m_lru[s][w] = w;
                end
            end
        end
        if (lru_update) begin
            ref_cnt = m_lru[idx][mw];
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (m_lru[idx][w] > ref_cnt) begin
                    m_lru[idx][w]--;
                end
            end
            m_lru[idx][mw] = `DC_WAYS - 1;
            m_lru_set[idx] = 1'b1;
        end
    endtask

    function automatic expected_t expected_outputs();
        dc_addr_t   a;
        expected_t  e;
        int         idx;
        int         vic;
        int         mw;
        int         wo;
        logic [5:0] off;
        a   = dc_addr_t'(data_addr);
        idx = int'(a.index);
        vic = victim_of(idx);
        mw  = match_way_of(idx, a.tag);
        wo  = int'(a.word_off);
        off = data_addr[5:0];
        e   = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == a.tag) begin
                e.hit = 1'b1;
            end
        end
        e.dirty = m_dirty[idx][vic];
        case (store_type)
            st_half:  e.store_ma = off[0];
            st_word:  e.store_ma = off[1] | off[0];
            st_dword: e.store_ma = off[2] | off[1] | off[0];
            default:  e.store_ma = 1'b0;
        endcase
        e.data_known = m_known[idx][mw];
        e.data[31:0] = m_block[idx][mw].words[wo];
        if (wo != DC_WORDS - 1) begin
            e.data[63:32] = m_block[idx][mw].words[wo + 1];
        end
        e.block_known = m_known[idx][vic];
        e.block       = m_block[idx][vic];
        if (addr_control) begin
            e.axi_known = 1'b1;
            e.addr_axi  = {data_addr[`DC_MEM_ADDR_W-1:`DC_BLOCK_OFF_W], 6'b0};
        end else begin
            e.axi_known = m_known[idx][vic];
            e.addr_axi  = {m_tag[idx][vic][WB_TAG_W-1:0], a.index, 6'b0};
        end
        return e;
    endfunction

    // -----------------------------------------------------------------------
    // Checking
    // -----------------------------------------------------------------------
    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic check(input string name, input logic [`DC_BLOCK_W-1:0] got,
                         input logic [`DC_BLOCK_W-1:0] want);
        if (got !== want) begin
            err_count++;
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
            stop_run();
        end
    endtask

    task automatic compare_outputs();
        expected_t e;
        e = expected_outputs();
        check("o_hit", hit, e.hit);
        check("o_dirty", dirty, e.dirty);
        check("o_store_addr_ma", store_ma, e.store_ma);
        if (e.data_known) begin
            check("o_data", rd_data, e.data);
        end
        if (e.block_known) begin
            check("o_data_block", victim_block, e.block);
        end
        if (e.axi_known) begin
            check("o_addr_axi", addr_axi, e.addr_axi);
        end
    endtask

    // Outputs are sampled just before each rising edge.
    always begin
        @(posedge clk);
        #(CLK_PERIOD - DRIVE_DELAY);
        if (check_en) begin
            compare_outputs();
        end
    end

    // -----------------------------------------------------------------------
    // Sequences
    // -----------------------------------------------------------------------
    task automatic run_cycle(input dc_ctrl_t ctrl);
        write_en       = ctrl.write_en;
        valid_update   = ctrl.valid_update;
        lru_update     = ctrl.lru_update;
        block_write_en = ctrl.block_write_en;
        @(posedge clk);
        update_model();
        #DRIVE_DELAY;
        {write_en, valid_update, lru_update, block_write_en} = '0;
    endtask

    task automatic idle_cycle();
        run_cycle('0);
    endtask

    task automatic wait_reset_clear();
        int n;
        n = 0;
        while (hit !== 1'b0 || dirty !== 1'b0) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout: hit and dirty flags did not clear after reset.");
                stop_run();
            end
            idle_cycle();
            n++;
        end
    endtask

    task automatic wait_for_hit();
        int n;
        n = 0;
        while (hit !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout: the filled line never reported a hit.");
                stop_run();
            end
            idle_cycle();
            n++;
        end
    endtask

    // Block write, valid update, then LRU update.
    task automatic fill_line(input int idx, input dc_tag_t tag);
        data_addr  = make_addr(tag, idx, random_below(64));
        data_block = random_block();
        run_cycle(CTRL_FILL);
        run_cycle(CTRL_VALID);
        run_cycle(CTRL_LRU);
        wait_for_hit();
    endtask

    task automatic touch_line(input int idx, input int way);
        data_addr = make_addr(m_tag[idx][way], idx, random_below(64));
        run_cycle(CTRL_LRU);
    endtask

    initial begin
        int          s;
        int          w;
        int          off;
        dc_tag_t     old_tag;
        dc_tag_t     new_tag;
        clk            = 1'b0;
        arst           = 1'b1;
        write_en       = 1'b0;
        valid_update   = 1'b0;
        lru_update     = 1'b0;
        block_write_en = 1'b0;
        addr_control   = 1'b0;
        data_addr      = '0;
        data           = '0;
        data_block     = '0;
        store_type     = st_byte;
        seed           = 32'd36994;
        err_count      = 0;
        check_en       = 1'b0;
        reset_model();
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        arst = 1'b0;
        wait_reset_clear();
        check_en = 1'b1;

        // Empty cache misses everywhere.
        for (int i = 0; i < 8; i++) begin
            data_addr = {next_random(), next_random()};
            idle_cycle();
        end

        // Fill every way, then read all word offsets.
        for (int si = 0; si < `DC_SETS; si++) begin
            for (int wi = 0; wi < `DC_WAYS; wi++) begin
                fill_line(si, random_tag());
            end
        end
        for (int i = 0; i < 24; i++) begin
            s         = random_below(`DC_SETS);
            w         = random_below(`DC_WAYS);
            off       = (i < DC_WORDS) ? 4 * i : random_below(64);
            data_addr = make_addr(m_tag[s][w], s, off);
            idle_cycle();
        end

        // Aligned stores of all sizes with a read after each.
        for (int i = 0; i < 32; i++) begin
            store_type = dc_store_e'(random_below(4));
            s          = random_below(`DC_SETS);
            w          = random_below(`DC_WAYS);
            off        = random_below(64) & ~((1 << int'(store_type)) - 1);
            data_addr  = make_addr(m_tag[s][w], s, off);
            data       = {next_random(), next_random()};
            run_cycle(CTRL_STORE);
            idle_cycle();
        end
        for (int si = 0; si < `DC_SETS; si++) begin
            touch_line(si, 1);
            idle_cycle();
            touch_line(si, 0);
            idle_cycle();
        end

        // Misalignment flag over every offset.
        for (int t = 0; t < 4; t++) begin
            for (int o = 0; o < 64; o++) begin
                store_type = dc_store_e'(t);
                data_addr  = {next_random(), next_random()};
                data_addr[5:0] = 6'(o);
                idle_cycle();
            end
        end

        // Fill address and write-back address.
        for (int i = 0; i < 8; i++) begin
            s         = random_below(`DC_SETS);
            w         = random_below(`DC_WAYS);
            data_addr = make_addr(m_tag[s][w], s, random_below(64));
            addr_control = 1'b1;
            idle_cycle();
            addr_control = 1'b0;
            idle_cycle();
        end

        // Replacement of the least recently used way.
        for (int si = 0; si < `DC_SETS; si++) begin
            touch_line(si, 0);
            old_tag = m_tag[si][1];
            new_tag = random_tag();
            fill_line(si, new_tag);
            data_addr = make_addr(old_tag, si, 0);
            idle_cycle();
            check("o_hit", hit, 1'b0);
            touch_line(si, 0);
            data_addr = make_addr(new_tag, si, 0);
            idle_cycle();
            check("o_hit", hit, 1'b1);
            check("o_dirty", dirty, 1'b0);
        end

        if (err_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

// File: list.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/store_align_check.sv
hdl/tag_array.sv
hdl/lru_tracker.sv
hdl/block_store.sv
hdl/dcache_top.sv
tb/dcache_tb.sv
